//--- verilog.f
+incdir+include
hw/zmem_pkg.sv
hw/zclk_gen.sv
hw/zmem.sv
hw/video_fetch.sv
hw/dram_slot_ctrl.sv
hw/zmem_top.sv
dv/zmem_sva.sv
dv/zmem_tb.sv

//--- Bender.yml
package:
  name: zmem

export_include_dirs:
  - include

sources:
  - files:
      - hw/zmem_pkg.sv
      - hw/zclk_gen.sv
      - hw/zmem.sv
      - hw/video_fetch.sv
      - hw/dram_slot_ctrl.sv
      - hw/zmem_top.sv
  - target: test
    files:
      - dv/zmem_sva.sv
      - dv/zmem_tb.sv

//--- dv/zmem_tb.sv
`include "zmem_defines.svh"

module zmem_tb import zmem_pkg::*;;

	// accesses in the whole run times the worst 3.5 MHz bus cycle
	localparam int ACCESSES  = 220;
	localparam int WORST_CYC = 80;
	localparam int LIMIT     = ACCESSES * WORST_CYC;

	logic        fclk;
	logic        rst;
	zbus_t       zbus;
	turbo_e      turbo;
	logic [7:0]  page;
	logic        rw_en;
	logic        romnram;
	logic        dos_on;
	logic [7:0]  zd_out;
	logic        zd_ena;
	logic        romoe_n;
	logic        romwe_n;
	logic        csrom;
	logic        zpos;
	logic        zneg;
	logic [15:0] vid_data;
	logic        vid_strobe;

	int          err_cnt;
	int          chk_cnt;
	int          cyc_cnt;
	logic [31:0] seed;
	// byte image of the dram, indexed by aliased word address and byte lane
	logic [7:0]  shadow [0:131071];
	bit          known [0:131071];

	zmem_top zmem_top_inst (
		.fclk       (fclk),
		.rst        (rst),
		.zbus       (zbus),
		.turbo      (turbo),
		.page       (page),
		.rw_en      (rw_en),
		.romnram    (romnram),
		.dos_on     (dos_on),
		.zd_out     (zd_out),
		.zd_ena     (zd_ena),
		.romoe_n    (romoe_n),
		.romwe_n    (romwe_n),
		.csrom      (csrom),
		.zpos       (zpos),
		.zneg       (zneg),
		.vid_data   (vid_data),
		.vid_strobe (vid_strobe)
	);

	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	// run limit
	always @(posedge fclk)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt > LIMIT)
		begin
			$display("timeout: no end of test after %0d cycles", LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 16 stored word address bits are page[2:0] and za[13:1]
	function automatic logic [16:0] byte_idx(input logic [7:0] pg, input logic [15:0] a);
		return {pg[2:0], a[13:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (exp !== act)
		begin
			err_cnt++;
			$display("ERR %s expected %h got %h", name, exp, act);
		end
	endtask

	// returns on the falling edge inside a zneg pulse
	task automatic wait_zneg(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(negedge fclk);
			while (!zneg)
				@(negedge fclk);
		end
	endtask

	// idle bus, z80 edges half a period apart
	task automatic zclk_period_check(input int period);
		int n;
		@(negedge fclk);
		while (!zpos)
			@(negedge fclk);
		n = 1;
		@(negedge fclk);
		while (!zneg)
		begin
			@(negedge fclk);
			n++;
		end
		check("zneg", period / 2, n);
		n = 1;
		@(negedge fclk);
		while (!zpos)
		begin
			@(negedge fclk);
			n++;
		end
		check("zpos", period / 2, n);
	endtask

	task automatic end_cycle();
		@(negedge fclk);
		while (zmem_top_inst.cpu_stall)
			@(negedge fclk);
		zbus.mreq = 1'b0;
		zbus.iorq = 1'b0;
		zbus.rd   = 1'b0;
		zbus.wr   = 1'b0;
		// idle long enough for a c3 to clear the request history
		wait_zneg(2);
	endtask

	task automatic z_write(input logic [7:0] pg, input logic [15:0] a, input logic [7:0] d);
		wait_zneg(1);
		page       = pg;
		zbus.za    = a;
		zbus.zd_in = d;
		zbus.mreq  = 1'b1;
		zbus.wr    = 1'b1;
		wait_zneg(4);
		end_cycle();
		if (!romnram)
		begin
			shadow[byte_idx(pg, a)] = d;
			known[byte_idx(pg, a)]  = 1'b1;
		end
	endtask

	task automatic z_read(input logic [7:0] pg, input logic [15:0] a, output logic [7:0] d);
		wait_zneg(1);
		page      = pg;
		zbus.za   = a;
		zbus.mreq = 1'b1;
		zbus.rd   = 1'b1;
		// stalls hold zneg back until the word is in
		wait_zneg(4);
		check("zd_ena", 1, zd_ena);
		d = zd_out;
		end_cycle();
	endtask

	task automatic read_check(input logic [7:0] pg, input logic [15:0] a);
		logic [7:0] d;
		z_read(pg, a, d);
		if (known[byte_idx(pg, a)])
			check("zd_out", shadow[byte_idx(pg, a)], d);
	endtask

	task automatic rom_access(input bit wr_cyc, input logic [7:0] pg, input logic [15:0] a,
		input logic [7:0] d);
		wait_zneg(1);
		page       = pg;
		zbus.za    = a;
		zbus.zd_in = d;
		zbus.mreq  = 1'b1;
		zbus.rd    = !wr_cyc;
		zbus.wr    = wr_cyc;
		wait_zneg(1);
		check("csrom", 1, csrom);
		check("romoe_n", wr_cyc, romoe_n);
		check("romwe_n", !(wr_cyc && rw_en), romwe_n);
		check("zd_ena", 0, zd_ena);
		wait_zneg(2);
		end_cycle();
	endtask

	task automatic io_cycle();
		wait_zneg(1);
		zbus.za   = 16'h00fe;
		zbus.iorq = 1'b1;
		zbus.rd   = 1'b1;
		wait_zneg(4);
		end_cycle();
	endtask

	task automatic dos_pulse();
		@(negedge fclk);
		dos_on = 1'b1;
		@(negedge fclk);
		dos_on = 1'b0;
	endtask

	// random bytes outside the screen page, then read back both lanes
	task automatic rand_rw_test(input int n);
		logic [7:0]  pg;
		logic [15:0] a;
		logic [7:0]  pgs [$];
		logic [15:0] as [$];
		int          i;
		for (i = 0; i < n; i++)
		begin
			seed = xorshift(seed);
			pg   = seed[7:0];
			if (pg[2:0] == 3'd5)
				pg[0] = ~pg[0];
			a = seed[23:8];
			z_write(pg, a, seed[31:24]);
			pgs.push_back(pg);
			as.push_back(a);
		end
		for (i = 0; i < n; i++)
		begin
			read_check(pgs[i], as[i]);
			read_check(pgs[i], as[i] ^ 16'h0001);
		end
	endtask

	task automatic paging_test();
		logic [7:0] d;
		z_write(8'h01, 16'h1234, 8'h11);
		z_write(8'h02, 16'h1234, 8'h22);
		z_read(8'h01, 16'h1234, d);
		check("zd_out", 8'h11, d);
		z_read(8'h02, 16'h1234, d);
		check("zd_out", 8'h22, d);
	endtask

	task automatic rom_test();
		@(negedge fclk);
		romnram = 1'b1;
		rw_en   = 1'b0;
		rom_access(1'b0, 8'h01, 16'h1234, 8'h00);
		rom_access(1'b1, 8'h01, 16'h1234, 8'hee);
		@(negedge fclk);
		rw_en = 1'b1;
		rom_access(1'b1, 8'h01, 16'h1234, 8'hee);
		@(negedge fclk);
		rw_en   = 1'b0;
		romnram = 1'b0;
		// ram behind the rom window untouched
		read_check(8'h01, 16'h1234);
	endtask

	task automatic cache_test();
		logic [15:0] a;
		a = 16'h0200;
		z_write(8'h03, a, 8'h5a);
		z_write(8'h03, a + 16'd1, 8'ha5);
		read_check(8'h03, a);
		// second read of the word hits
		read_check(8'h03, a);
		z_write(8'h03, a + 16'd1, 8'h3c);
		read_check(8'h03, a + 16'd1);
		read_check(8'h03, a);
		io_cycle();
		z_write(8'h03, a + 16'd1, 8'hc3);
		read_check(8'h03, a + 16'd1);
		read_check(8'h03, a);
		dos_pulse();
		z_write(8'h03, a + 16'd1, 8'h96);
		read_check(8'h03, a + 16'd1);
		read_check(8'h03, a);
	endtask

	function automatic logic [15:0] screen_word(input int i);
		logic [15:0] w;
		w = `VID_BASE_WADDR + i;
		return {shadow[{w, 1'b1}], shadow[{w, 1'b0}]};
	endfunction

	task automatic wait_vid();
		@(negedge fclk);
		while (!vid_strobe)
			@(negedge fclk);
	endtask

	task automatic video_collect();
		int   k;
		int   n;
		bit   found;
		found = 1'b0;
		k     = 0;
		// skip fetches that may predate the last screen write
		repeat (2) wait_vid();
		wait_vid();
		for (n = 0; n < `VID_WORDS; n++)
		begin
			if (!found && screen_word(n) === vid_data)
			begin
				found = 1'b1;
				k     = n;
			end
		end
		if (!found)
		begin
			err_cnt++;
			$display("video word %h matches no word of the screen area", vid_data);
		end
		else
		begin
			for (n = 1; n <= `VID_WORDS + 8; n++)
			begin
				wait_vid();
				check("vid_data", screen_word((k + n) % `VID_WORDS), vid_data);
			end
		end
	endtask

	task automatic video_test();
		int i;
		// screen is page 5, za from 0; low byte unique per word
		for (i = 0; i < `VID_WORDS; i++)
		begin
			seed = xorshift(seed);
			z_write(8'h05, 16'(2 * i), 8'h40 + 8'(i));
			z_write(8'h05, 16'(2 * i + 1), seed[7:0]);
		end
		fork
			video_collect();
			rand_rw_test(8);
		join
	endtask

	initial
	begin
		rst     = 1'b1;
		zbus    = '0;
		turbo   = TURBO_14M;
		page    = 8'h00;
		rw_en   = 1'b0;
		romnram = 1'b0;
		dos_on  = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		cyc_cnt = 0;
		seed    = 32'hf7fe;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		rst = 1'b0;

		turbo = TURBO_3M5;
		zclk_period_check(8);
		rand_rw_test(8);
		@(negedge fclk);
		turbo = TURBO_7M;
		zclk_period_check(4);
		rand_rw_test(8);
		@(negedge fclk);
		turbo = TURBO_14M;
		zclk_period_check(2);
		rand_rw_test(8);
		paging_test();
		rom_test();
		cache_test();
		video_test();

		$display("errors: %0d of %0d checks", err_cnt, chk_cnt);
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- dv/zmem_sva.sv
module zmem_sva import zmem_pkg::*; (
	input logic        fclk,
	input logic        rst,
	input slot_phase_t phase,
	input logic        cpu_req,
	input logic        cpu_next,
	input logic        cpu_strobe,
	input logic        vid_strobe,
	input logic        cpu_stall,
	input logic        ramreq,
	input slot_owner_e owner
);

	logic ram_seen;

	// first ram cycle after reset
	always_ff @(posedge fclk)
	begin
		if (rst)
			ram_seen <= 1'b0;
		else if (ramreq)
			ram_seen <= 1'b1;
	end

	// one slot carries one strobe
	a_strobe_excl: assert property (@(posedge fclk) disable iff (rst)
		!(cpu_strobe && vid_strobe))
		else $error("cpu and video strobes in the same cycle");

	// worst case is one video slot ahead of the cpu
	// the held request must be taken and the slot must go to the cpu
	a_grant: assert property (@(posedge fclk) disable iff (rst)
		$rose(cpu_req) |-> ##[0:7] (cpu_req && cpu_next && phase.c3) ##1 (owner == OWN_CPU))
		else $error("cpu request not granted within two slots");

	a_idle_stall: assert property (@(posedge fclk) disable iff (rst)
		(!ram_seen && !ramreq) |-> !cpu_stall)
		else $error("cpu stall before any ram access");

endmodule

bind zmem_top zmem_sva zmem_sva_inst (
	.fclk       (fclk),
	.rst        (rst),
	.phase      (phase),
	.cpu_req    (cpu_req),
	.cpu_next   (cpu_next),
	.cpu_strobe (cpu_strobe),
	.vid_strobe (slot_vid_strobe),
	.cpu_stall  (cpu_stall),
	.ramreq     (zmem_inst.ramreq),
	.owner      (dram_slot_ctrl_inst.owner)
);

//--- hw/zmem_top.sv
`include "zmem_defines.svh"

module zmem_top import zmem_pkg::*; (
	input  logic        fclk,
	input  logic        rst,
	input  zbus_t       zbus,
	input  turbo_e      turbo,
	input  logic [7:0]  page,
	input  logic        rw_en,
	input  logic        romnram,
	input  logic        dos_on,
	output logic [7:0]  zd_out,
	output logic        zd_ena,
	output logic        romoe_n,
	output logic        romwe_n,
	output logic        csrom,
	output logic        zpos,
	output logic        zneg,
	output logic [15:0] vid_data,
	output logic        vid_strobe
);

	slot_phase_t              phase;
	logic                     cpu_stall;
	logic                     cpu_req;
	dram_req_t                cpu_req_d;
	logic [15:0]              cpu_rddata;
	logic                     cpu_next;
	logic                     cpu_strobe;
	logic                     vid_req;
	logic [`ZMEM_WADDR_W-1:0] vid_waddr;
	logic                     vid_next;
	// raw slot strobe, vid_strobe is the registered word valid
	logic                     slot_vid_strobe;
	logic [15:0]              vid_rddata;

	zclk_gen zclk_gen_inst (
		.fclk      (fclk),
		.rst       (rst),
		.turbo     (turbo),
		.cpu_stall (cpu_stall),
		.phase     (phase),
		.zpos      (zpos),
		.zneg      (zneg)
	);

	zmem zmem_inst (
		.fclk       (fclk),
		.rst        (rst),
		.phase      (phase),
		.zpos       (zpos),
		.zneg       (zneg),
		.zbus       (zbus),
		.turbo      (turbo),
		.page       (page),
		.rw_en      (rw_en),
		.romnram    (romnram),
		.dos_on     (dos_on),
		.zd_out     (zd_out),
		.zd_ena     (zd_ena),
		.romoe_n    (romoe_n),
		.romwe_n    (romwe_n),
		.csrom      (csrom),
		.cpu_req    (cpu_req),
		.cpu_req_d  (cpu_req_d),
		.cpu_rddata (cpu_rddata),
		.cpu_next   (cpu_next),
		.cpu_strobe (cpu_strobe),
		.cpu_stall  (cpu_stall)
	);

	video_fetch video_fetch_inst (
		.fclk       (fclk),
		.rst        (rst),
		.phase      (phase),
		.vid_req    (vid_req),
		.vid_waddr  (vid_waddr),
		.vid_next   (vid_next),
		.vid_strobe (slot_vid_strobe),
		.vid_rddata (vid_rddata),
		.vid_data   (vid_data),
		.vid_valid  (vid_strobe)
	);

	dram_slot_ctrl dram_slot_ctrl_inst (
		.fclk       (fclk),
		.rst        (rst),
		.phase      (phase),
		.vid_req    (vid_req),
		.vid_waddr  (vid_waddr),
		.vid_next   (vid_next),
		.vid_strobe (slot_vid_strobe),
		.vid_rddata (vid_rddata),
		.cpu_req    (cpu_req),
		.cpu_req_d  (cpu_req_d),
		.cpu_next   (cpu_next),
		.cpu_strobe (cpu_strobe),
		.cpu_rddata (cpu_rddata)
	);

endmodule

//--- hw/dram_slot_ctrl.sv
`include "zmem_defines.svh"

module dram_slot_ctrl import zmem_pkg::*; (
	input  logic                     fclk,
	input  logic                     rst,
	input  slot_phase_t              phase,
	input  logic                     vid_req,
	input  logic [`ZMEM_WADDR_W-1:0] vid_waddr,
	output logic                     vid_next,
	output logic                     vid_strobe,
	output logic [15:0]              vid_rddata,
	input  logic                     cpu_req,
	input  dram_req_t                cpu_req_d,
	output logic                     cpu_next,
	output logic                     cpu_strobe,
	output logic [15:0]              cpu_rddata
);

	localparam int DEPTH = 2 ** `ZMEM_RAM_AW;

	slot_owner_e              owner;
	logic [`ZMEM_RAM_AW-1:0]  slot_addr;
	logic                     slot_rnw;
	logic [7:0]               slot_wdata;
	logic                     slot_bsel;
	logic [15:0]              rd_q;
	logic [15:0]              mem [DEPTH];

	// next-slot flags hold for the whole slot
	// video never takes two slots in a row
	assign vid_next = vid_req & (owner != OWN_VIDEO);
	assign cpu_next = ~vid_next;

	// owner of the coming slot picked at c3
	always_ff @(posedge fclk)
	begin
		if (rst)
			owner <= OWN_IDLE;
		else if (phase.c3)
		begin
			if (vid_next)
				owner <= OWN_VIDEO;
			else if (cpu_req)
				owner <= OWN_CPU;
			else
				owner <= OWN_IDLE;
		end
	end

	// request latched at grant
	// cpu bus may move on while the slot runs
	always_ff @(posedge fclk)
	begin
		if (phase.c3)
		begin
			if (vid_next)
			begin
				slot_addr  <= vid_waddr[`ZMEM_RAM_AW-1:0];
				slot_rnw   <= 1'b1;
				slot_wdata <= 8'h00;
				slot_bsel  <= 1'b0;
			end
			else
			begin
				slot_addr  <= cpu_req_d.waddr[`ZMEM_RAM_AW-1:0];
				slot_rnw   <= cpu_req_d.rnw;
				slot_wdata <= cpu_req_d.wrdata;
				slot_bsel  <= cpu_req_d.wrbsel;
			end
		end
	end

	// array access at c1 of the slot
	// a write touches only its byte lane
	always_ff @(posedge fclk)
	begin
		if (phase.c1 && owner != OWN_IDLE)
		begin
			if (slot_rnw)
				rd_q <= mem[slot_addr];
			else if (slot_bsel)
				mem[slot_addr][15:8] <= slot_wdata;
			else
				mem[slot_addr][7:0] <= slot_wdata;
		end
	end

	// read word valid at c2
	assign cpu_strobe = (owner == OWN_CPU) & slot_rnw & phase.c2;
	assign vid_strobe = (owner == OWN_VIDEO) & phase.c2;
	assign cpu_rddata = rd_q;
	assign vid_rddata = rd_q;

endmodule

//--- hw/video_fetch.sv
`include "zmem_defines.svh"

module video_fetch import zmem_pkg::*; (
	input  logic                     fclk,
	input  logic                     rst,
	input  slot_phase_t              phase,
	output logic                     vid_req,
	output logic [`ZMEM_WADDR_W-1:0] vid_waddr,
	input  logic                     vid_next,
	input  logic                     vid_strobe,
	input  logic [15:0]              vid_rddata,
	output logic [15:0]              vid_data,
	output logic                     vid_valid
);

	localparam int CNT_W = $clog2(`VID_PERIOD_SLOTS);
	localparam int OFS_W = $clog2(`VID_WORDS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`VID_PERIOD_SLOTS - 1);
	localparam logic [OFS_W-1:0] OFS_LAST = OFS_W'(`VID_WORDS - 1);

	logic [CNT_W-1:0] slot_cnt;
	logic [OFS_W-1:0] ofs;

	// slot counter paces the requests
	// request stays up for one slot and is granted at its c3
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			slot_cnt <= '0;
			vid_req  <= 1'b0;
		end
		else if (phase.c3)
		begin
			slot_cnt <= (slot_cnt == CNT_LAST) ? '0 : slot_cnt + 1'b1;
			if (vid_req && vid_next)
				vid_req <= 1'b0;
			else if (slot_cnt == CNT_LAST)
				vid_req <= 1'b1;
		end
	end

	// screen offset steps once the word is back
	always_ff @(posedge fclk)
	begin
		if (rst)
			ofs <= '0;
		else if (vid_strobe)
			ofs <= (ofs == OFS_LAST) ? '0 : ofs + 1'b1;
	end

	assign vid_waddr = `VID_BASE_WADDR + {{(`ZMEM_WADDR_W - OFS_W){1'b0}}, ofs};

	// fetched word with a one-cycle valid
	always_ff @(posedge fclk)
	begin
		if (vid_strobe)
			vid_data <= vid_rddata;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			vid_valid <= 1'b0;
		else
			vid_valid <= vid_strobe;
	end

endmodule

//--- hw/zmem.sv
`include "zmem_defines.svh"

module zmem import zmem_pkg::*; (
	input  logic        fclk,
	input  logic        rst,
	input  slot_phase_t phase,
	input  logic        zpos,
	input  logic        zneg,
	input  zbus_t       zbus,
	input  turbo_e      turbo,
	input  logic [7:0]  page,
	input  logic        rw_en,
	input  logic        romnram,
	input  logic        dos_on,
	output logic [7:0]  zd_out,
	output logic        zd_ena,
	output logic        romoe_n,
	output logic        romwe_n,
	output logic        csrom,
	output logic        cpu_req,
	output dram_req_t   cpu_req_d,
	input  logic [15:0] cpu_rddata,
	input  logic        cpu_next,
	input  logic        cpu_strobe,
	output logic        cpu_stall
);

	logic                     is14;
	logic                     ramreq;
	logic                     ramrd;
	logic                     ramwr;
	logic                     opfetch;
	logic [`ZMEM_WADDR_W-1:0] cur_waddr;
	logic                     cache_hit;
	logic                     mreq_n_q;
	logic                     cyc_beg;
	logic                     dram_beg;
	logic                     stall14_ini;
	logic                     stall14;
	stall_st_e                st14;
	logic                     pend;
	logic                     rnw_q;
	logic                     ramrd_q;
	logic                     ramwr_q;
	logic                     req357;
	logic                     io_q;
	logic                     cache_kill;
	logic                     cache_valid;
	logic [`ZMEM_WADDR_W-1:0] cache_tag;
	logic [15:0]              rd_buf;

	// bus decode
	assign is14    = (turbo == TURBO_14M);
	assign ramreq  = zbus.mreq & ~romnram;
	assign ramrd   = ramreq & zbus.rd;
	assign ramwr   = ramreq & zbus.wr;
	assign opfetch = ramrd & zbus.m1;

	// rom strobes, csrom is positive polarity
	// rw_en only unlocks rom writes
	assign csrom   = romnram;
	assign romoe_n = ~(zbus.mreq & zbus.rd & romnram);
	assign romwe_n = ~(zbus.mreq & zbus.wr & romnram & rw_en);
	assign zd_ena  = ramrd;

	// paged word address and one-word cache lookup
	assign cur_waddr = {page, zbus.za[13:1]};
	assign cache_hit = cache_valid && (cache_tag == cur_waddr);

	// mreq rise seen at z80 negative edge
	always_ff @(posedge fclk)
	begin
		if (rst)
			mreq_n_q <= 1'b1;
		else if (zneg)
			mreq_n_q <= ~zbus.mreq;
	end

	assign cyc_beg  = zneg & mreq_n_q & zbus.mreq;
	// cache hits never reach dram
	assign dram_beg = is14 & cyc_beg & ((ramrd & ~cache_hit) | ramwr);

	// wait tables in 14 MHz mode
	// reads hold until the slot is granted, then until the data is back
	// fetches get one more cycle than plain reads
	// writes wait only for a free cpu slot
	assign stall14_ini = dram_beg & (~cpu_next | ramrd);

	always_ff @(posedge fclk)
	begin
		if (rst)
			st14 <= ST_IDLE;
		else
		begin
			case (st14)
				ST_IDLE:
					if (dram_beg && ramrd)
						st14 <= (cpu_next && phase.c3) ? ST_FIN : ST_CYC;
				ST_CYC:
					// granted at this c3
					if (cpu_next && phase.c3)
						st14 <= ST_FIN;
				ST_FIN:
					// rd_buf loads at the c2 edge
					if (opfetch ? phase.c3 : phase.c2)
						st14 <= ST_IDLE;
				default:
					st14 <= ST_IDLE;
			endcase
		end
	end

	assign stall14 = stall14_ini | (ramwr ? ~cpu_next : (st14 == ST_CYC)) | (st14 == ST_FIN);

	// request held past dram_beg until granted
	always_ff @(posedge fclk)
	begin
		if (rst)
			pend <= 1'b0;
		else if (cpu_next && phase.c3)
			pend <= 1'b0;
		else if (dram_beg)
			pend <= 1'b1;
	end

	always_ff @(posedge fclk)
	begin
		if (dram_beg)
			rnw_q <= ~ramwr;
	end

	// slow modes issue one request per rising ram read or write
	// history updates at c3 once the request went out
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			ramrd_q <= 1'b0;
			ramwr_q <= 1'b0;
		end
		else if (phase.c3 && !cpu_stall)
		begin
			ramrd_q <= ramrd;
			ramwr_q <= ramwr;
		end
	end

	assign req357 = (ramrd & ~ramrd_q) | (ramwr & ~ramwr_q);

	assign cpu_stall = is14 ? stall14 : (req357 & ~cpu_next);
	assign cpu_req   = is14 ? (pend | dram_beg) : req357;

	always_comb
	begin
		cpu_req_d.waddr  = cur_waddr;
		cpu_req_d.rnw    = (is14 && !dram_beg) ? rnw_q : ~ramwr;
		cpu_req_d.wrdata = zbus.zd_in;
		cpu_req_d.wrbsel = zbus.za[0];
	end

	// cache drops on rom cycles, ram writes, io rise and dos switch
	assign cache_kill = (cyc_beg & romnram) | (cyc_beg & ramwr)
		| (zpos & zbus.iorq & ~io_q) | dos_on;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			io_q        <= 1'b0;
			cache_valid <= 1'b0;
		end
		else
		begin
			if (zpos)
				io_q <= zbus.iorq;
			if (cache_kill)
				cache_valid <= 1'b0;
			else if (cpu_strobe)
				cache_valid <= 1'b1;
		end
	end

	// read word and its tag
	always_ff @(posedge fclk)
	begin
		if (cpu_strobe)
		begin
			rd_buf    <= cpu_rddata;
			cache_tag <= cur_waddr;
		end
	end

	// odd za takes the high byte
	assign zd_out = zbus.za[0] ? rd_buf[15:8] : rd_buf[7:0];

endmodule

//--- hw/zclk_gen.sv
module zclk_gen import zmem_pkg::*; (
	input  logic        fclk,
	input  logic        rst,
	input  turbo_e      turbo,
	input  logic        cpu_stall,
	output slot_phase_t phase,
	output logic        zpos,
	output logic        zneg
);

	logic [3:0] ring;
	logic [2:0] div;
	logic [2:0] div_nxt;
	logic       pos_nxt;
	logic       neg_nxt;

	// slot ring runs free and ignores stall
	always_ff @(posedge fclk)
	begin
		if (rst)
			ring <= 4'b0001;
		else
			ring <= {ring[2:0], ring[3]};
	end

	assign phase = ring;

	// z80 half-period divider
	assign div_nxt = div + 3'd1;

	// edge decode of the next divider value
	always_comb
	begin
		case (turbo)
			TURBO_14M:
			begin
				// one fclk per half period
				pos_nxt = (div_nxt[0] == 1'b0);
				neg_nxt = (div_nxt[0] == 1'b1);
			end
			TURBO_7M:
			begin
				pos_nxt = (div_nxt[1:0] == 2'd0);
				neg_nxt = (div_nxt[1:0] == 2'd2);
			end
			default:
			begin
				// 3.5 MHz uses the whole counter
				pos_nxt = (div_nxt == 3'd0);
				neg_nxt = (div_nxt == 3'd4);
			end
		endcase
	end

	// strobes are registered so stall never loops back into them
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			div  <= 3'd0;
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else if (cpu_stall)
		begin
			// freeze z80 clock where it stands
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			div  <= div_nxt;
			zpos <= pos_nxt;
			zneg <= neg_nxt;
		end
	end

endmodule

//--- hw/zmem_pkg.sv
`include "zmem_defines.svh"

package zmem_pkg;

	// z80 clock speed select
	typedef enum logic [1:0] {
		TURBO_3M5 = 2'd0,
		TURBO_7M  = 2'd1,
		TURBO_14M = 2'd2
	} turbo_e;

	// z80 bus lines as seen by the memory manager
	// control lines are active high here
	typedef struct packed {
		logic [15:0] za;
		logic [7:0]  zd_in;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} zbus_t;

	// one dram slot request
	// wrbsel picks the byte lane of a write, 0 is the low byte
	typedef struct packed {
		logic [`ZMEM_WADDR_W-1:0] waddr;
		logic                     rnw;
		logic [7:0]               wrdata;
		logic                     wrbsel;
	} dram_req_t;

	// owner of the slot in flight
	typedef enum logic [1:0] {
		OWN_IDLE  = 2'd0,
		OWN_VIDEO = 2'd1,
		OWN_CPU   = 2'd2
	} slot_owner_e;

	// one-hot slot phase
	typedef struct packed {
		logic c3;
		logic c2;
		logic c1;
		logic c0;
	} slot_phase_t;

	// wait state machine of the 14 MHz mode
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_CYC  = 2'd1,
		ST_FIN  = 2'd2
	} stall_st_e;

endpackage

//--- include/zmem_defines.svh
`ifndef ZMEM_DEFINES_SVH
`define ZMEM_DEFINES_SVH

// word address made of page[7:0] and za[13:1]
`define ZMEM_WADDR_W 21

// word address bits kept by the simulated dram array
// upper page bits alias onto lower ones
`define ZMEM_RAM_AW 16

// screen area read by the video fetcher
// page 5 word 0 in the paged word address space
`define VID_BASE_WADDR 21'h00A000
`define VID_WORDS 32

// slots between two video requests
// must be at least 2 so the cpu always gets a slot in between
`define VID_PERIOD_SLOTS 4

`endif
